// File: design/execPkg.sv
// Execute unit package: operand width, opcode and state enums, command and response structs
`default_nettype none

package execPkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int xLen = 32;               // Operand and result width

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    opAdd  = 4'd0,                        // a + b
    opSub  = 4'd1,                        // a - b
    opSll  = 4'd2,                        // Shift left logical by b[4:0]
    opSrl  = 4'd3,                        // Shift right logical
    opSra  = 4'd4,                        // Shift right arithmetic
    opSlt  = 4'd5,                        // Signed less-than
    opSltu = 4'd6,                        // Unsigned less-than
    opXor  = 4'd7,
    opOr   = 4'd8,
    opAnd  = 4'd9,
    opMul  = 4'd10                        // Low half of a * b, iterative
  } aluOp;

  // Controller states
  typedef enum logic [1:0] {
    stIdle = 2'd0,                        // Waiting for req
    stRun  = 2'd1,                        // Command held, single-cycle result or mul start
    stMul  = 2'd2,                        // Shift-add iterations
    stDone = 2'd3                         // ack high until req drops
  } execState;

  ////////////////////////////////////////
  // Handshake payloads
  ////////////////////////////////////////

  typedef struct packed {
    aluOp            op;                  // 4 bits
    logic [xLen-1:0] a;
    logic [xLen-1:0] b;
  } execReq;                              // 68 bits, valid with req

  typedef struct packed {
    logic [xLen-1:0] result;
  } execResp;                             // Valid while ack is high

endpackage

`default_nettype wire

// File: design/shifter.sv
// Barrel shifter: logical and arithmetic right shifts, left shift through bit reversal
`timescale 1ns/1ps
`default_nettype none

module shifter import execPkg::*; (
  input  logic [xLen-1:0] a,              // Operand
  input  logic [4:0]      amt,            // Shift amount
  input  logic            right,          // 1 = right shift
  input  logic            arith,          // Sign fill on right shift
  output logic [xLen-1:0] y
);

  logic [xLen-1:0] revA;                  // Operand reversed for left shifts
  logic [xLen-1:0] revOut;                // Shifter output reversed back
  logic [xLen-1:0] stg [0:5];             // Barrel stages
  logic            fill;                  // Bit shifted in from the top

  // Left shift = reverse, shift right, reverse
  always_comb begin
    for (int i = 0; i < xLen; i++) begin
      revA[i]   = a[xLen-1-i];
      revOut[i] = stg[5][xLen-1-i];
    end
  end

  assign fill   = right & arith & a[xLen-1];  // Zero fill for left and logical shifts
  assign stg[0] = right ? a : revA;

  ////////////////////////////////////////
  // Log stages, 1/2/4/8/16
  ////////////////////////////////////////

  for (genvar i = 0; i < 5; i++) begin : gStage
    localparam int sh = 2 ** i;
    assign stg[i+1] = amt[i] ? {{sh{fill}}, stg[i][xLen-1:sh]} : stg[i];
  end

  assign y = right ? stg[5] : revOut;

endmodule

`default_nettype wire

// File: design/alu.sv
// Single-cycle ALU: shared adder/subtractor, compare flags, shifter and logic ops, result select
`timescale 1ns/1ps
`default_nettype none

module alu import execPkg::*; (
  input  aluOp            op,             // Opcode from the controller
  input  logic [xLen-1:0] a,
  input  logic [xLen-1:0] b,
  output logic [xLen-1:0] result
);

  logic            subArith;              // Subtract, or arithmetic shift
  logic            shRight;               // Shift direction
  logic [2:0]      resSel;                // Result mux select
  logic [xLen-1:0] condInvB;              // ~b when subtracting
  logic [xLen-1:0] sum;                   // Adder output
  logic [xLen-1:0] shiftY;                // Shifter output
  logic            carry;                 // Adder carry out
  logic            neg, aSign, bSign;
  logic            lt, ltu;                // Compare flags

  ////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////

  always_comb begin
    subArith = 1'b0;
    shRight  = 1'b0;
    resSel   = 3'd7;                      // Zero unless decoded
    case (op)
      opAdd:  resSel = 3'd0;
      opSub:  begin subArith = 1'b1; resSel = 3'd0; end
      opSll:  resSel = 3'd1;
      opSrl:  begin shRight = 1'b1; resSel = 3'd1; end
      opSra:  begin shRight = 1'b1; subArith = 1'b1; resSel = 3'd1; end
      opSlt:  begin subArith = 1'b1; resSel = 3'd2; end
      opSltu: begin subArith = 1'b1; resSel = 3'd3; end
      opXor:  resSel = 3'd4;
      opOr:   resSel = 3'd5;
      opAnd:  resSel = 3'd6;
      default: resSel = 3'd7;             // opMul handled by the iterative path
    endcase
  end

  // One adder for add, sub, slt, sltu
  assign condInvB       = subArith ? ~b : b;
  assign {carry, sum}   = {1'b0, a} + {1'b0, condInvB} + {{xLen{1'b0}}, subArith};

  // Shift amount is the low 5 bits of b
  shifter sh (.a(a), .amt(b[4:0]), .right(shRight), .arith(subArith), .y(shiftY));

  ////////////////////////////////////////
  // Flags from a - b
  ////////////////////////////////////////

  // Signed compare without a separate overflow flag
  assign neg   = sum[xLen-1];
  assign aSign = a[xLen-1];
  assign bSign = b[xLen-1];
  assign lt    = (aSign & ~bSign) | (aSign & neg) | (~bSign & neg);
  assign ltu   = ~carry;                  // Borrow out of the subtraction

  // Result select
  always_comb begin
    case (resSel)
      3'd0:    result = sum;                          // add, sub
      3'd1:    result = shiftY;                       // sll, srl, sra
      3'd2:    result = {{(xLen-1){1'b0}}, lt};       // slt
      3'd3:    result = {{(xLen-1){1'b0}}, ltu};      // sltu
      3'd4:    result = a ^ b;
      3'd5:    result = a | b;
      3'd6:    result = a & b;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/mulIter.sv
// Shift-add multiplier datapath: multiplicand, multiplier and accumulator, one partial product per step
`timescale 1ns/1ps
`default_nettype none

module mulIter import execPkg::*; #(
  parameter int mulSteps = 32             // Iterations = multiplier bits used
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            start,          // Load operands, clear accumulator
  input  logic            en,             // Advance one step
  input  logic [xLen-1:0] a,
  input  logic [xLen-1:0] b,
  output logic [xLen-1:0] product         // Accumulator after the current step
);

  // Only the low mulSteps bits of b take part
  localparam logic [xLen-1:0] bMask =
    (mulSteps >= xLen) ? {xLen{1'b1}} : {xLen{1'b1}} >> (xLen - mulSteps);

  logic [xLen-1:0] mcand;                 // Multiplicand, shifts left
  logic [xLen-1:0] mplier;                // Multiplier, shifts right
  logic [xLen-1:0] acc;                   // Running sum, low bits only
  logic [xLen-1:0] accNext;

  // Partial product added when the low multiplier bit is set
  assign accNext = acc + (mplier[0] ? mcand : '0);

  ////////////////////////////////////////
  // Step registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      acc    <= '0;
      mplier <= '0;
    end else if (start) begin
      acc    <= '0;
      mplier <= b & bMask;
    end else if (en) begin
      acc    <= accNext;
      mplier <= mplier >> 1;
    end
  end

  // Multiplicand datapath
  always_ff @(posedge clk) begin
    if (start) mcand <= a;
    else if (en) mcand <= mcand << 1;     // Upper bits drop off
  end

  // Controller latches this on the last step, so it includes that step
  assign product = accNext;

endmodule

`default_nettype wire

// File: design/stepCounter.sv
// Loadable down-counter pacing multi-cycle operations, flags the final step
`timescale 1ns/1ps
`default_nettype none

module stepCounter #(
  parameter int mulSteps = 32             // Steps per operation
) (
  input  logic clk,
  input  logic rstN,
  input  logic load,                      // Start of an operation
  input  logic en,                        // Count one step
  output logic lastStep                   // Count has reached zero
);

  localparam int cntW = (mulSteps > 1) ? $clog2(mulSteps) : 1;

  logic [cntW-1:0] count;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      count <= '0;
    end else if (load) begin
      count <= cntW'(mulSteps - 1);       // mulSteps cycles down to zero
    end else if (en && (count != '0)) begin
      count <= count - 1'b1;
    end
  end

  assign lastStep = (count == '0);

endmodule

`default_nettype wire

// File: design/execCtrl.sv
// Execute controller: handshake FSM, command capture, path choice and result latch
`timescale 1ns/1ps
`default_nettype none

module execCtrl import execPkg::*; (
  input  logic            clk,
  input  logic            rstN,
  input  logic            req,
  input  execReq          cmd,
  output logic            ack,
  output execResp         rsp,
  output execPkg::aluOp   aluOp,          // Captured opcode to the ALU
  output logic [xLen-1:0] opA,
  output logic [xLen-1:0] opB,
  input  logic [xLen-1:0] aluResult,
  output logic            mulStart,       // Load counter and multiplier
  output logic            stepEn,         // Advance multiplier and counter
  input  logic            lastStep,
  input  logic [xLen-1:0] mulProduct
);

  execState state, stateNext;
  execReq   cmdQ;                         // Command held for the whole transaction
  logic     isMul;                        // Iterative path
  logic     latchRes;                     // Write rsp this cycle
  logic [xLen-1:0] resNext;

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) state <= stIdle;
    else       state <= stateNext;
  end

  always_comb begin
    stateNext = state;
    case (state)
      stIdle: if (req) stateNext = stRun;        // New command
      stRun:  stateNext = isMul ? stMul : stDone;
      stMul:  if (lastStep) stateNext = stDone;  // Final shift-add step
      stDone: if (!req) stateNext = stIdle;      // Requester released
      default: stateNext = stIdle;
    endcase
  end

  // Capture only when accepting
  always_ff @(posedge clk) begin
    if ((state == stIdle) && req) cmdQ <= cmd;
  end

  assign isMul = (cmdQ.op == opMul);

  ////////////////////////////////////////
  // Result latch
  ////////////////////////////////////////

  always_comb begin
    latchRes = 1'b0;
    resNext  = aluResult;
    if ((state == stRun) && !isMul) begin
      latchRes = 1'b1;                    // Single-cycle result
    end else if ((state == stMul) && lastStep) begin
      latchRes = 1'b1;
      resNext  = mulProduct;
    end
  end

  // Held stable through stDone
  always_ff @(posedge clk) begin
    if (latchRes) rsp.result <= resNext;
  end

  // Datapath controls
  assign aluOp    = cmdQ.op;
  assign opA      = cmdQ.a;
  assign opB      = cmdQ.b;
  assign mulStart = (state == stRun) && isMul;  // One-cycle pulse
  assign stepEn   = (state == stMul);
  assign ack      = (state == stDone);    // Falls the edge after req is seen low

endmodule

`default_nettype wire

// File: design/execUnit.sv
// Execute unit top level: controller, step counter, ALU and iterative multiplier
`timescale 1ns/1ps
`default_nettype none

module execUnit import execPkg::*; #(
  parameter int mulSteps = 32             // Shift-add iterations for opMul
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    req,                    // Four-phase request
  input  execReq  cmd,                    // Stable while req is high
  output logic    ack,
  output execResp rsp                     // Valid while ack is high
);

  ////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////

  aluOp            aluOpSel;              // Captured opcode
  logic [xLen-1:0] opA, opB;              // Captured operands
  logic [xLen-1:0] aluResult;
  logic [xLen-1:0] mulProduct;
  logic            mulStart, stepEn, lastStep;

  // Handshake and sequencing
  execCtrl u_execCtrl (
    .clk        (clk),
    .rstN       (rstN),
    .req        (req),
    .cmd        (cmd),
    .ack        (ack),
    .rsp        (rsp),
    .aluOp      (aluOpSel),
    .opA        (opA),
    .opB        (opB),
    .aluResult  (aluResult),
    .mulStart   (mulStart),
    .stepEn     (stepEn),
    .lastStep   (lastStep),
    .mulProduct (mulProduct)
  );

  // Single-cycle ops
  alu u_alu (.op(aluOpSel), .a(opA), .b(opB), .result(aluResult));

  ////////////////////////////////////////
  // Multi-cycle path
  ////////////////////////////////////////

  stepCounter #(.mulSteps(mulSteps)) u_stepCounter (
    .clk      (clk),
    .rstN     (rstN),
    .load     (mulStart),
    .en       (stepEn),
    .lastStep (lastStep)
  );

  mulIter #(.mulSteps(mulSteps)) u_mulIter (
    .clk     (clk),
    .rstN    (rstN),
    .start   (mulStart),
    .en      (stepEn),
    .a       (opA),
    .b       (opB),
    .product (mulProduct)
  );

endmodule

`default_nettype wire

// File: test/execUnit_assertions.sv
// Bound controller checks: handshake, capture window, response hold, reset state
`timescale 1ns/1ps
`default_nettype none

module execUnit_assertions import execPkg::*; (
  input logic     clk,
  input logic     rstN,
  input logic     req,
  input logic     ack,
  input execState state,
  input execReq   cmdQ,                   // Captured command
  input execResp  rsp
);

  int unsigned failCount = 0;             // Failed checks, read at end of run

  function automatic void flagFailure(input string what);
    failCount++;
    $error("%s", what);
  endfunction

  // ack only answers a live request
  ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN) $rose(ack) |-> req)
    else flagFailure("ack rose while req was low");

  // Command register moves only on acceptance in stIdle
  captureInIdle: assert property (@(posedge clk) disable iff (!rstN)
    (state != stIdle) |=> $stable(cmdQ)) else flagFailure("cmd captured outside stIdle");

  // Response held for the whole ack phase
  rspHeld: assert property (@(posedge clk) disable iff (!rstN) ack |=> (!ack || $stable(rsp)))
    else flagFailure("rsp changed while ack was high");

  // Reset leaves the handshake idle
  resetIdle: assert property (@(posedge clk) !rstN |=> (!ack && state == stIdle))
    else flagFailure("ack or state not idle after reset");

endmodule

bind execCtrl execUnit_assertions u_assertions (.*);

`default_nettype wire

// File: test/execUnitTb.sv
// Execute unit testbench: clock, reset, file and random commands, reference model, checks
`timescale 1ns/1ps
`default_nettype none

module execUnitTb import execPkg::*; ();

  localparam int mulSteps  = 32;          // Shift-add iterations in the DUT
  localparam int fileCmds  = 22;          // Lines in the stimulus file
  localparam int randCmds  = 200;
  localparam int clkPeriod = 4;           // ns

  logic        clk = 1'b0;
  logic        rstN, req, ack;
  execReq      cmd;
  execResp     rsp;
  logic [31:0] stimMem [0:4*fileCmds-1];  // op, a, b, expected per command
  logic [31:0] seed;                      // xorshift state

  always #(clkPeriod / 2) clk = ~clk;

  execUnit #(.mulSteps(mulSteps)) u_execUnit (.*);

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic checkResp(input execResp got, input execResp exp, input string what);
    if (got !== exp)
      abortRun($sformatf("mismatch at %0t ns: %s rsp %h, expected %h",
                         $time, what, got.result, exp.result));
  endtask

  task automatic checkAck(input logic got, input logic exp, input string what);
    if (got !== exp)
      abortRun($sformatf("mismatch at %0t ns: %s ack %b, expected %b", $time, what, got, exp));
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);  // 13/17/5 variant
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  // Expected result from the RV32 opcode rules
  function automatic logic [xLen-1:0] refResult(input aluOp op, input logic [xLen-1:0] a, b);
    case (op)
      opAdd:   return a + b;                              // Wraps mod 2^32
      opSub:   return a - b;
      opSll:   return a << b[4:0];                        // Low 5 bits of b only
      opSrl:   return a >> b[4:0];
      opSra:   return $signed(a) >>> b[4:0];              // Bit 31 replicated
      opSlt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      opSltu:  return (a < b) ? 32'd1 : 32'd0;
      opXor:   return a ^ b;
      opOr:    return a | b;
      opAnd:   return a & b;
      opMul:   return a * b;                              // Low half of the product
      default: return '0;
    endcase
  endfunction

  // One four-phase transaction with a back-pressure cycle
  task automatic runCmd(input execReq c, input logic [xLen-1:0] expRes, input string what);
    execResp exp;
    exp.result = expRes;
    @(negedge clk);
    cmd = c;                              // Phase 1, cmd stable with req
    req = 1'b1;
    while (!ack) @(negedge clk);          // Phase 2, any number of cycles
    checkResp(rsp, exp, what);
    cmd = execReq'(~c);                   // Unit must ignore cmd while in stDone
    @(negedge clk);
    checkAck(ack, 1'b1, {what, " held"});
    checkResp(rsp, exp, {what, " held"});
    req = 1'b0;                           // Phase 3
    @(negedge clk);
    checkAck(ack, 1'b0, {what, " release"});  // Phase 4, one edge later
  endtask

  initial begin
    execReq c;
    rstN = 1'b0;
    req  = 1'b0;
    cmd  = '0;
    seed = 32'ha977;
    $readmemh("test/execStimulus.hex", stimMem);
    repeat (16) @(negedge clk);           // 16 cycles of reset
    rstN = 1'b1;
    checkAck(ack, 1'b0, "after reset");
    // Directed commands with expected results from the file
    for (int i = 0; i < fileCmds; i++) begin
      c.op = aluOp'(stimMem[4*i][3:0]);
      c.a  = stimMem[4*i+1];
      c.b  = stimMem[4*i+2];
      runCmd(c, stimMem[4*i+3], $sformatf("file cmd %0d", i));
    end
    // Random commands over all opcodes
    for (int i = 0; i < randCmds; i++) begin
      seed = xorshift(seed);
      c.op = aluOp'(4'(seed % 11));
      seed = xorshift(seed);
      c.a  = seed;
      seed = xorshift(seed);
      c.b  = seed;
      runCmd(c, refResult(c.op, c.a, c.b), $sformatf("random cmd %0d", i));
    end
    if (u_execUnit.u_execCtrl.u_assertions.failCount != 0) begin
      abortRun("bound assertions on the controller reported failures");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

  // Each command gets the full multiply length plus handshake slack
  initial begin
    #((fileCmds + randCmds) * (mulSteps + 8) * clkPeriod);
    abortRun("timeout: the DUT did not finish all commands in time");
  end

endmodule

`default_nettype wire

// File: project.f
design/execPkg.sv
design/shifter.sv
design/alu.sv
design/mulIter.sv
design/stepCounter.sv
design/execCtrl.sv
design/execUnit.sv
test/execUnit_assertions.sv
test/execUnitTb.sv

// File: Bender.yml
package:
  name: exec_unit

sources:
  - design/execPkg.sv
  - design/shifter.sv
  - design/alu.sv
  - design/mulIter.sv
  - design/stepCounter.sv
  - design/execCtrl.sv
  - design/execUnit.sv
  - target: test
    files:
      - test/execUnit_assertions.sv
      - test/execUnitTb.sv

// File: test/execStimulus.hex
// op a b expected, hex; op 0 add 1 sub 2 sll 3 srl 4 sra 5 slt 6 sltu 7 xor 8 or 9 and a mul
0 7fffffff 00000001 80000000
0 ffffffff 00000001 00000000
1 00000000 00000001 ffffffff
1 80000000 00000001 7fffffff
5 00000005 00000005 00000000
5 ffffffff 00000001 00000001
5 80000000 7fffffff 00000001
6 ffffffff 00000001 00000000
6 00000001 ffffffff 00000001
2 00000001 0000001f 80000000
2 12345678 00000024 23456780
3 80000000 0000001f 00000001
4 80000000 0000001f ffffffff
4 70000000 00000024 07000000
7 ff00ff00 0ff00ff0 f0f0f0f0
8 ff00ff00 0ff00ff0 fff0fff0
9 ff00ff00 0ff00ff0 0f000f00
a 00000000 12345678 00000000
a 00000001 87654321 87654321
a ffffffff ffffffff 00000001
a 0000ffff 0000ffff fffe0001
a fffffffe 00000003 fffffffa
